/* cpuConsts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ************************************************************
// Core and memory sizes
// ************************************************************

`define CPU_DATA_W 8
`define CPU_ADDR_W 8
`define CPU_MEM_DEPTH 256

// byte shown on the test port.
`define CPU_TEST_ADDR 96

// first instruction fetched after reset.
`define CPU_RESET_PC 8'h00

`endif

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

	// ************************************************************
	// Instruction set
	// ************************************************************

	typedef enum logic [3:0] {
		opNop = 4'h0,
		opLda = 4'h1, // acc gets mem[operand].
		opSta = 4'h2, // mem[operand] gets acc.
		opAdd = 4'h3,
		opSub = 4'h4, // carry holds the borrow.
		opAnd = 4'h5,
		opOr = 4'h6,
		opXor = 4'h7,
		opJmp = 4'h8,
		opJz = 4'h9,
		opJc = 4'hA,
		opHlt = 4'hF
	} opcodeT;

	typedef enum logic [2:0] {
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor
	} aluOpT;

	typedef enum logic [1:0] {
		stFetch,
		stOperand,
		stExecute,
		stHalted
	} cpuStateT;

endpackage

`default_nettype wire

/* list.f */
+incdir+.
cpuPkg.sv
memBus.sv
upAlu.sv
upMemory.sv
upControl.sv
upTop.sv
tbUpTop.sv

/* memBus.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

interface memBus;

	logic [`CPU_ADDR_W-1:0] address;
	logic [`CPU_DATA_W-1:0] wrData;
	logic we;
	logic [`CPU_DATA_W-1:0] rdData; // combinational from address.

	modport cpu (
		output address,
		output wrData,
		output we,
		input rdData
	);

	modport mem (
		input address,
		input wrData,
		input we,
		output rdData
	);

endinterface

`default_nettype wire

/* run.sh */
#!/bin/sh
# compiles the design and testbench with Verilator, then runs the simulation.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbUpTop -f list.f -o simUpTop
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/simUpTop > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^all tests passed$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* tbUpTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module tbUpTop;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int MAX_INSTR = 200;
	localparam int NUM_TESTS = 5;
	localparam int LOAD_CYCLES = 3 * `CPU_MEM_DEPTH + 2 * RESET_CYCLES;
	localparam int WATCHDOG_NS = CLK_PERIOD * NUM_TESTS * (3 * MAX_INSTR + LOAD_CYCLES);

	logic clk, nRst, run, hostWe;
	logic [`CPU_ADDR_W-1:0] hostAddress;
	logic [`CPU_DATA_W-1:0] hostData;
	logic [`CPU_DATA_W-1:0] hostRdData, test;
	logic [`CPU_ADDR_W-1:0] pc;
	logic halted;

	logic [`CPU_DATA_W-1:0] image [0:`CPU_MEM_DEPTH-1];
	logic [`CPU_DATA_W-1:0] modelMem [0:`CPU_MEM_DEPTH-1];
	logic [`CPU_ADDR_W-1:0] modelPc;
	logic [15:0] prog [$]; // opcode byte in the high half, operand byte in the low half.
	integer seed = 32'hd000;

	upTop u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#WATCHDOG_NS;
		failRun("the simulation timed out before all tests finished");
	end

	task automatic failRun(input string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic checkByte(input string name, input logic [`CPU_DATA_W-1:0] expected,
			input logic [`CPU_DATA_W-1:0] actual);
		if (actual !== expected) begin
			failRun($sformatf("FAIL time=%0t %s expected=%h actual=%h",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			failRun($sformatf("FAIL time=%0t %s expected=%b actual=%b",
				$time, name, expected, actual));
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			failRun($sformatf("FAIL time=%0t %s expected=%0d actual=%0d",
				$time, name, expected, actual));
		end
	endtask

	// ************************************************************
	// Reference model of the instruction set
	// ************************************************************

	function automatic int runProgram();
		logic [`CPU_ADDR_W-1:0] p;
		logic [`CPU_DATA_W-1:0] arg;
		logic [`CPU_DATA_W-1:0] acc;
		logic [3:0] op;
		logic z;
		logic c;
		p = `CPU_RESET_PC;
		acc = '0;
		z = 1'b0;
		c = 1'b0;
		for (int n = 1; n <= MAX_INSTR; n++) begin
			op = modelMem[p][7:4]; // low nibble carries no meaning.
			arg = modelMem[p + 8'd1];
			p = p + 8'd2;
			case (op)
				4'h1: acc = modelMem[arg];
				4'h2: modelMem[arg] = acc;
				4'h3: {c, acc} = {1'b0, acc} + {1'b0, modelMem[arg]};
				4'h4: {c, acc} = {1'b0, acc} - {1'b0, modelMem[arg]};
				4'h5: {c, acc} = {1'b0, acc & modelMem[arg]};
				4'h6: {c, acc} = {1'b0, acc | modelMem[arg]};
				4'h7: {c, acc} = {1'b0, acc ^ modelMem[arg]};
				4'h8: p = arg;
				4'h9: if (z) p = arg;
				4'hA: if (c) p = arg;
				4'hF: begin
					modelPc = p;
					return n;
				end
				default: ;
			endcase
			if (op == 4'h1 || (op >= 4'h3 && op <= 4'h7)) z = (acc == '0);
		end
		return -1; // the program never reached HLT.
	endfunction

	task automatic placeProgram();
		for (int i = 0; i < `CPU_MEM_DEPTH; i++) image[i] = '0;
		foreach (prog[i]) begin
			image[2 * i] = prog[i][15:8];
			image[2 * i + 1] = prog[i][7:0];
		end
	endtask

	task automatic applyReset();
		@(posedge clk);
		nRst <= 1'b0;
		run <= 1'b0;
		hostWe <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		nRst <= 1'b1;
	endtask

	// ************************************************************
	// Run the core until it halts
	// ************************************************************

	// only edges that saw run high are counted, and pc must hold across the others.
	task automatic runCore(input bit gate, output int cycles);
		logic [`CPU_ADDR_W-1:0] heldPc;
		bit wasLow;
		cycles = 0;
		@(posedge clk);
		run <= 1'b1;
		@(negedge clk);
		while (!halted) begin
			heldPc = pc;
			@(posedge clk);
			wasLow = !run; // the level this edge sampled.
			if (run) cycles++;
			run <= gate ? (($random(seed) & 3) != 0) : 1'b1;
			@(negedge clk);
			if (wasLow) checkByte("pc", heldPc, pc);
		end
	endtask

	task automatic runTest(input bit load, input bit gate);
		int count;
		int cycles;
		modelMem = image;
		count = runProgram();
		if (count < 0) failRun("the reference model found no HLT within the instruction limit");
		applyReset();
		for (int i = 0; load && i < `CPU_MEM_DEPTH; i++) begin
			@(posedge clk);
			hostWe <= 1'b1;
			hostAddress <= 8'(i);
			hostData <= image[i];
		end
		@(posedge clk);
		hostWe <= 1'b0;
		runCore(gate, cycles);
		checkCount("cycles", 3 * count, cycles);
		for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
			@(posedge clk);
			hostAddress <= 8'(i);
			@(negedge clk);
			checkByte($sformatf("mem[%0d]", i), modelMem[i], hostRdData);
		end
		checkByte("test", modelMem[`CPU_TEST_ADDR], test);
		checkByte("pc", modelPc, pc);
		checkFlag("halted", 1'b1, halted); // halt holds until the next reset.
	endtask

	initial begin
		nRst = 1'b0;
		run = 1'b0;
		hostWe = 1'b0;
		hostAddress = '0;
		hostData = '0;

		// the boot image as the memory builds it at reset.
		prog = '{16'h1080, 16'h3081, 16'h2060, 16'hF000};
		placeProgram();
		image[128] = 8'h25;
		image[129] = 8'h17;
		runTest(1'b0, 1'b0);
		checkByte("test", 8'h3C, test);

		prog = '{16'h10C8, 16'h33C9, 16'h27D2, 16'h4ACA, 16'h21D3, 16'h5FCB, 16'h22D4,
			16'h69CC, 16'h2BD5, 16'h70CD, 16'hC000, 16'h2E60, 16'hF700};
		placeProgram();
		for (int i = 200; i < 206; i++) image[i] = 8'($random(seed));
		runTest(1'b1, 1'b0);

		// Countdown loop on JZ, then a JC branch that picks the byte stored at 96.
		prog = '{16'h109F, 16'h3197, 16'h209F, 16'h1096, 16'h4097, 16'h2096, 16'h9010,
			16'h8000, 16'h1099, 16'h309A, 16'hA01A, 16'h109D, 16'h801C, 16'h109E,
			16'h2060, 16'hF000};
		for (int round = 0; round < 2; round++) begin
			placeProgram();
			image[150] = 8'(1 + {$random(seed)} % 12);
			image[151] = 8'h01;
			for (int i = 153; i < 159; i++) image[i] = 8'($random(seed));
			runTest(1'b1, round == 1); // the second round drops run at random.
		end

		applyReset();
		for (int k = 0; k < 8; k++) begin
			@(posedge clk);
			hostWe <= 1'b1;
			hostAddress <= (k == 7) ? 8'(`CPU_TEST_ADDR) : 8'($random(seed));
			hostData <= 8'($random(seed));
			@(posedge clk);
			hostWe <= 1'b0;
			@(negedge clk);
			checkByte("hostRdData", hostData, hostRdData);
		end
		checkByte("test", hostData, test);
		checkByte("pc", `CPU_RESET_PC, pc); // the core stayed stopped.
		checkFlag("halted", 1'b0, halted);

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* upAlu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module upAlu (
	input cpuPkg::aluOpT op,
	input logic [`CPU_DATA_W-1:0] a,
	input logic [`CPU_DATA_W-1:0] b,
	input logic carryIn,
	output logic [`CPU_DATA_W-1:0] result,
	output logic carry,
	output logic zero
);
	import cpuPkg::*;

	logic [`CPU_DATA_W:0] wide; // one extra bit for carry or borrow.

	always_comb begin
		wide = '0;
		result = b;
		carry = carryIn;
		case (op)
			aluAdd: begin
				wide = {1'b0, a} + {1'b0, b};
				result = wide[`CPU_DATA_W-1:0];
				carry = wide[`CPU_DATA_W];
			end
			aluSub: begin
				wide = {1'b0, a} - {1'b0, b}; // top bit set means a borrow.
				result = wide[`CPU_DATA_W-1:0];
				carry = wide[`CPU_DATA_W];
			end
			aluAnd: begin
				result = a & b;
				carry = 1'b0;
			end
			aluOr: begin
				result = a | b;
				carry = 1'b0;
			end
			aluXor: begin
				result = a ^ b;
				carry = 1'b0;
			end
			default: result = b; // pass leaves carry alone.
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* upControl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module upControl (
	input logic clk,
	input logic nRst,
	input logic run,
	memBus.cpu bus,
	output logic halted,
	output logic [`CPU_ADDR_W-1:0] pc
);
	import cpuPkg::*;

	cpuStateT state;
	opcodeT opcode;
	logic [`CPU_ADDR_W-1:0] operand;
	logic [`CPU_DATA_W-1:0] acc;
	logic zeroFlag;
	logic carryFlag;

	aluOpT aluOp;
	logic [`CPU_DATA_W-1:0] aluResult;
	logic aluCarry;
	logic aluZero;
	logic writesAcc;
	logic takeJump;

	// ************************************************************
	// Decode
	// ************************************************************

	always_comb begin
		aluOp = aluPass;
		writesAcc = 1'b1;
		case (opcode)
			opLda: aluOp = aluPass;
			opAdd: aluOp = aluAdd;
			opSub: aluOp = aluSub;
			opAnd: aluOp = aluAnd;
			opOr: aluOp = aluOr;
			opXor: aluOp = aluXor;
			default: writesAcc = 1'b0; // stores, jumps and undefined codes keep acc.
		endcase
	end

	always_comb begin
		case (opcode)
			opJmp: takeJump = 1'b1;
			opJz: takeJump = zeroFlag;
			opJc: takeJump = carryFlag;
			default: takeJump = 1'b0;
		endcase
	end

	upAlu u_alu (
		.op(aluOp),
		.a(acc),
		.b(bus.rdData),
		.carryIn(carryFlag),
		.result(aluResult),
		.carry(aluCarry),
		.zero(aluZero)
	);

	// only the execute cycle looks at the operand address.
	assign bus.address = (state == stExecute) ? operand : pc;
	assign bus.wrData = acc;
	assign bus.we = run && (state == stExecute) && (opcode == opSta);
	assign halted = (state == stHalted);

	// ************************************************************
	// Instruction sequencer
	// ************************************************************

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= stFetch;
			pc <= `CPU_RESET_PC;
			opcode <= opNop;
			operand <= '0;
			acc <= '0;
			zeroFlag <= 1'b0;
			carryFlag <= 1'b0;
		end else if (run) begin
			case (state)
				stFetch: begin
					opcode <= opcodeT'(bus.rdData[`CPU_DATA_W-1 -: 4]); // low nibble ignored.
					pc <= pc + 1'b1;
					state <= stOperand;
				end
				stOperand: begin
					operand <= bus.rdData;
					pc <= pc + 1'b1;
					state <= stExecute;
				end
				stExecute: begin
					if (writesAcc) begin
						acc <= aluResult;
						zeroFlag <= aluZero;
						carryFlag <= aluCarry;
					end
					if (takeJump) begin
						pc <= operand;
					end
					state <= (opcode == opHlt) ? stHalted : stFetch;
				end
				default: state <= stHalted; // only reset leaves halt.
			endcase
		end
	end

	// a store always ends its instruction, so the next cycle fetches.
	assert property (@(posedge clk) disable iff (!nRst) bus.we |=> state == stFetch)
		else $error("memory write did not end its instruction");

	// run is sampled at the previous edge, so that edge must not have moved pc.
	assert property (@(posedge clk) disable iff (!nRst) !$past(run) |-> $stable(pc))
		else $error("pc changed while run was low");

endmodule

`default_nettype wire

/* upMemory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module upMemory (
	input logic clk,
	input logic nRst,
	memBus.mem bus,
	input logic hostWe,
	input logic [`CPU_ADDR_W-1:0] hostAddress,
	input logic [`CPU_DATA_W-1:0] hostData,
	output logic [`CPU_DATA_W-1:0] hostRdData,
	output logic [`CPU_DATA_W-1:0] test
);

	logic [`CPU_DATA_W-1:0] mem [0:`CPU_MEM_DEPTH-1];

	// boot program is LDA 128, ADD 129, STA 96, HLT.
	function automatic logic [`CPU_DATA_W-1:0] bootByte(input int unsigned idx);
		logic [`CPU_DATA_W-1:0] val;
		val = '0;
		case (idx)
			0: val = 8'h10;
			1: val = 8'h80;
			2: val = 8'h30;
			3: val = 8'h81;
			4: val = 8'h20;
			5: val = 8'h60;
			6: val = 8'hF0;
			128: val = 8'h25;
			129: val = 8'h17;
			default: val = '0;
		endcase
		return val;
	endfunction

	assign bus.rdData = mem[bus.address];
	assign hostRdData = mem[hostAddress];
	assign test = mem[`CPU_TEST_ADDR];

	// ************************************************************
	// Write port shared by host and core
	// ************************************************************

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
				mem[i] <= bootByte(i);
			end
		end else if (hostWe) begin
			mem[hostAddress] <= hostData; // host only writes while the core is stopped.
		end else if (bus.we) begin
			mem[bus.address] <= bus.wrData;
		end
	end

	// the host loads only while run is low, so the core can never collide with it.
	assert property (@(posedge clk) disable iff (!nRst) !(hostWe && bus.we))
		else $error("host and core wrote memory in the same cycle");

endmodule

`default_nettype wire

/* upTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpuConsts.svh"

module upTop (
	input logic clk,
	input logic nRst,
	input logic run,
	input logic hostWe,
	input logic [`CPU_ADDR_W-1:0] hostAddress,
	input logic [`CPU_DATA_W-1:0] hostData,
	output logic [`CPU_DATA_W-1:0] hostRdData,
	output logic [`CPU_DATA_W-1:0] test,
	output logic [`CPU_ADDR_W-1:0] pc,
	output logic halted
);

	// ************************************************************
	// Core to memory
	// ************************************************************

	memBus memIf ();

	upControl u_control (
		.clk(clk),
		.nRst(nRst),
		.run(run),
		.bus(memIf.cpu),
		.halted(halted),
		.pc(pc)
	);

	// host port goes straight to the memory.
	upMemory u_memory (
		.clk(clk),
		.nRst(nRst),
		.bus(memIf.mem),
		.hostWe(hostWe),
		.hostAddress(hostAddress),
		.hostData(hostData),
		.hostRdData(hostRdData),
		.test(test)
	);

endmodule

`default_nettype wire
